/* rtl/hdc_pkg.sv */
package hdc_pkg;

    // hypervector and item memory geometry
    localparam int HV_WIDTH   = 32;
    localparam int ITEM_DEPTH = 100;
    localparam int NUM_CORES  = 8;

    // accepted symbol to accumulator update, in cycles
    localparam int PIPE_DEPTH = 3;

    // busy counter sizing for the apb wait states
    localparam int BUSY_W = $clog2(PIPE_DEPTH + 1);
    localparam logic [BUSY_W-1:0] BUSY_LOAD = BUSY_W'(PIPE_DEPTH);

    typedef logic [HV_WIDTH-1:0] hv_t;
    // 7 bits covers the 100 item entries
    typedef logic [6:0] sym_t;
    typedef logic [2:0] core_idx_t;
    // rotation amount, wraps modulo 32
    typedef logic [4:0] pos_t;

    // apb register map, byte offsets
    localparam logic [4:0] REG_CTRL     = 5'h00;
    localparam logic [4:0] REG_MEM_ADDR = 5'h04;
    localparam logic [4:0] REG_MEM_DATA = 5'h08;
    localparam logic [4:0] REG_SYM      = 5'h0C;
    localparam logic [4:0] REG_OUT      = 5'h10;

    // ctrl register bits
    localparam int CTRL_INIT_BIT    = 0;
    localparam int CTRL_CAPTURE_BIT = 1;

endpackage

/* rtl/hdc_ctrl_if.sv */
`timescale 1ns/1ns

interface hdc_ctrl_if;
    import hdc_pkg::*;

    // single-cycle command pulses
    logic init;
    logic capture;
    logic shift;

    // item write, seen by every core at once
    logic mem_we;
    sym_t mem_addr;
    hv_t  mem_data;

    // symbol plus one-hot core select
    sym_t sym;
    logic [NUM_CORES-1:0] exec;

    // apb side drives everything
    modport ctrl (
        output init, capture, shift, mem_we, mem_addr, mem_data, sym, exec
    );

    // cores only listen
    modport core (
        input init, capture, shift, mem_we, mem_addr, mem_data, sym, exec
    );

endinterface

/* rtl/item_memory.sv */
`timescale 1ns/1ns

module item_memory (
    input  logic         clk,
    input  logic         we,
    input  hdc_pkg::sym_t waddr,
    input  hdc_pkg::hv_t  wdata,
    input  logic         re,
    input  hdc_pkg::sym_t raddr,
    output hdc_pkg::hv_t  rdata
);
    import hdc_pkg::*;

    // one hypervector per symbol, mapped to block ram
    (* ram_style = "block" *) hv_t mem [0:ITEM_DEPTH-1];

    // identity contents until the bus master reprograms them
    initial begin
        for (int i = 0; i < ITEM_DEPTH; i++) begin
            mem[i] = hv_t'(i);
        end
    end

    // broadcast write port
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // registered read, holds its value when idle
    always_ff @(posedge clk) begin
        if (re) begin
            rdata <= mem[raddr];
        end
    end

endmodule

/* rtl/hdc_core.sv */
`timescale 1ns/1ns

module hdc_core #(
    parameter int CORE_ID = 0
) (
    input  logic         clk,
    input  logic         rst,
    hdc_ctrl_if.core     ctrl,
    input  hdc_pkg::hv_t chain_in,
    output hdc_pkg::hv_t chain_out
);
    import hdc_pkg::*;

    logic exec_bit;
    // valid pipe, one bit per stage
    logic v1;
    logic v2;
    logic v3;
    // lookup result, staging and final operand
    hv_t  lookup_hv;
    hv_t  stage_hv;
    hv_t  mix_hv;
    // rotation of the final operand
    logic [2*HV_WIDTH-1:0] rot_wide;
    hv_t  rot_hv;
    // encoder state
    hv_t  acc;
    pos_t pos;
    hv_t  chain_q;

    // this core's select bit
    assign exec_bit = ctrl.exec[CORE_ID];

    // private copy of the item table
    item_memory item_memory_inst (
        .clk   (clk),
        .we    (ctrl.mem_we),
        .waddr (ctrl.mem_addr),
        .wdata (ctrl.mem_data),
        .re    (exec_bit),
        .raddr (ctrl.sym),
        .rdata (lookup_hv)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            v1 <= 1'b0;
            v2 <= 1'b0;
            v3 <= 1'b0;
        end else begin
            v1 <= exec_bit;
            v2 <= v1;
            v3 <= v2;
        end
    end

    // staging breaks the ram to rotator path
    always_ff @(posedge clk) begin
        if (v1) begin
            stage_hv <= lookup_hv;
        end
        if (v2) begin
            mix_hv <= stage_hv;
        end
    end

    // rotate right by pos, upper copy wraps the low bits around
    assign rot_wide = {mix_hv, mix_hv} >> pos;
    assign rot_hv   = rot_wide[HV_WIDTH-1:0];

    // xor bundling
    // pos rotates at the last stage so back to back symbols see the updated count
    always_ff @(posedge clk) begin
        if (rst || ctrl.init) begin
            acc <= '0;
            pos <= '0;
        end else if (v3) begin
            acc <= acc ^ rot_hv;
            pos <= pos + 1'b1;
        end
    end

    // readout chain stage
    always_ff @(posedge clk) begin
        if (rst) begin
            chain_q <= '0;
        end else if (ctrl.capture) begin
            chain_q <= acc;
        end else if (ctrl.shift) begin
            chain_q <= chain_in;
        end
    end

    assign chain_out = chain_q;

endmodule

/* rtl/hdc_apb_ctrl.sv */
`timescale 1ns/1ns

module hdc_apb_ctrl (
    input  logic         clk,
    input  logic         rst,
    input  logic [4:0]   paddr,
    input  logic         psel,
    input  logic         penable,
    input  logic         pwrite,
    input  logic [31:0]  pwdata,
    output logic [31:0]  prdata,
    output logic         pready,
    output logic         pslverr,
    input  hdc_pkg::hv_t out_data,
    hdc_ctrl_if.ctrl     ctrl
);
    import hdc_pkg::*;

    logic access;
    logic done;
    // address decode
    logic sel_ctrl;
    logic sel_mem_addr;
    logic sel_mem_data;
    logic sel_sym;
    logic sel_out;
    logic mapped;
    // symbol write fields
    sym_t      sym_idx;
    core_idx_t sym_core;
    // range checks
    logic sym_bad;
    logic mem_bad;
    logic err;
    logic ok;
    // wait state source
    logic stall;
    logic [BUSY_W-1:0] busy_cnt;
    // mem_addr keeps full width so large values fail the range check
    logic [31:0] mem_addr_q;

    // access phase of a transfer
    assign access = psel && penable;

    assign sel_ctrl     = (paddr == REG_CTRL);
    assign sel_mem_addr = (paddr == REG_MEM_ADDR);
    assign sel_mem_data = (paddr == REG_MEM_DATA);
    assign sel_sym      = (paddr == REG_SYM);
    assign sel_out      = (paddr == REG_OUT);
    assign mapped       = sel_ctrl || sel_mem_addr || sel_mem_data || sel_sym || sel_out;

    assign sym_idx  = pwdata[6:0];
    assign sym_core = pwdata[10:8];

    assign sym_bad = pwrite && sel_sym && (sym_idx >= ITEM_DEPTH);
    assign mem_bad = pwrite && sel_mem_data && (mem_addr_q >= ITEM_DEPTH);
    assign err     = !mapped || sym_bad || mem_bad;

    // ctrl and out wait for the pipeline to drain
    assign stall  = (busy_cnt != '0) && (sel_ctrl || sel_out);
    assign pready = access && !stall;

    // completing cycle, side effects happen here
    assign done    = access && pready;
    assign pslverr = done && err;
    assign ok      = done && !err;

    // busy counter
    always_ff @(posedge clk) begin
        if (rst) begin
            busy_cnt <= '0;
        end else if (ok && pwrite && sel_sym) begin
            busy_cnt <= BUSY_LOAD;
        end else if (busy_cnt != '0) begin
            busy_cnt <= busy_cnt - 1'b1;
        end
    end

    // mem_addr register
    always_ff @(posedge clk) begin
        if (rst) begin
            mem_addr_q <= '0;
        end else if (ok && pwrite && sel_mem_addr) begin
            mem_addr_q <= pwdata;
        end
    end

    // command pulses
    assign ctrl.init    = ok && pwrite && sel_ctrl && pwdata[CTRL_INIT_BIT];
    assign ctrl.capture = ok && pwrite && sel_ctrl && pwdata[CTRL_CAPTURE_BIT];
    assign ctrl.shift   = ok && !pwrite && sel_out;

    // broadcast item write, address already range checked
    assign ctrl.mem_we   = ok && pwrite && sel_mem_data;
    assign ctrl.mem_addr = sym_t'(mem_addr_q);
    assign ctrl.mem_data = pwdata;

    // symbol dispatch, one-hot on the core field
    assign ctrl.sym = sym_idx;

    always_comb begin
        ctrl.exec = '0;
        if (ok && pwrite && sel_sym) begin
            ctrl.exec[sym_core] = 1'b1;
        end
    end

    // read mux
    // write-only registers read as zero
    always_comb begin
        prdata = '0;
        if (sel_mem_addr) begin
            prdata = mem_addr_q;
        end else if (sel_out) begin
            prdata = out_data;
        end
    end

endmodule

/* rtl/hdc_encoder_top.sv */
`timescale 1ns/1ns

module hdc_encoder_top (
    input  logic        clk,
    input  logic        rst,
    input  logic [4:0]  paddr,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr
);
    import hdc_pkg::*;

    // chain[k] feeds core k, chain[NUM_CORES] is the tail
    hv_t chain [0:NUM_CORES];

    // command bus to the core array
    hdc_ctrl_if ctrl_bus ();

    // head of the readout chain shifts in zeros
    assign chain[0] = '0;

    hdc_apb_ctrl hdc_apb_ctrl_inst (
        .clk      (clk),
        .rst      (rst),
        .paddr    (paddr),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr),
        .out_data (chain[NUM_CORES]),
        .ctrl     (ctrl_bus)
    );

    // core 7 sits at the tail, read out first
    generate
        for (genvar k = 0; k < NUM_CORES; k++) begin : g_core
            hdc_core #(
                .CORE_ID (k)
            ) hdc_core_inst (
                .clk       (clk),
                .rst       (rst),
                .ctrl      (ctrl_bus),
                .chain_in  (chain[k]),
                .chain_out (chain[k+1])
            );
        end
    endgenerate

endmodule

/* sim/tb_hdc_encoder.sv */
`timescale 1ns/1ns

module tb_hdc_encoder;
    import hdc_pkg::*;

    // apb transfers per test in run order
    localparam int XFERS = 21 + 409 + 49 + 30 + 15 + 25;
    localparam int CYCLES_PER_XFER = 200;

    logic        clk;
    logic        rst;
    logic [4:0]  paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    int seed = 32'he30b_22de;

    // reference model
    hv_t  item_m [0:ITEM_DEPTH-1];
    hv_t  acc_m [0:NUM_CORES-1];
    pos_t pos_m [0:NUM_CORES-1];
    // front is the next word out of the chain tail
    hv_t  chain_m [$];

    hdc_encoder_top hdc_encoder_top_inst (
        .clk     (clk),
        .rst     (rst),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    always #5 clk = ~clk;

    // watchdog
    initial begin
        repeat (XFERS * CYCLES_PER_XFER + 10) @(posedge clk);
        $display("timeout: the tests did not finish within %0d cycles",
                 XFERS * CYCLES_PER_XFER + 10);
        $display("Testbench failed");
        $fatal(1);
    end

    task automatic check_hv(input string name, input hv_t exp, input hv_t act);
        if (exp !== act) begin
            $display("ERR %s: expected %h, actual %h", name, exp, act);
            $display("Testbench failed");
            $fatal(1);
        end
    endtask

    task automatic check_err(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("ERR %s: expected pslverr %b, actual %b", name, exp, act);
            $display("Testbench failed");
            $fatal(1);
        end
    endtask

    // rotate right where a left shift of 32 drops out as zero
    function automatic hv_t rotr(input hv_t v, input pos_t p);
        return (v >> p) | (v << (6'd32 - p));
    endfunction

    function automatic sym_t rand_sym();
        return sym_t'($unsigned($random(seed)) % ITEM_DEPTH);
    endfunction

    function automatic core_idx_t rand_core();
        return core_idx_t'($unsigned($random(seed)) % NUM_CORES);
    endfunction

    // setup then access, entered and left 1 ns after a rising edge
    task automatic apb_xfer(input logic wr, input logic [4:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge clk);
        #1;
        penable = 1'b1;
        // sample mid-cycle away from the edge
        @(negedge clk);
        while (!pready) @(negedge clk);
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic send_sym(input core_idx_t c, input sym_t s);
        logic [31:0] rdata;
        logic        err;
        apb_xfer(1'b1, REG_SYM, {21'b0, c, 1'b0, s}, rdata, err);
        check_err("symbol write", 1'b0, err);
        acc_m[c] = acc_m[c] ^ rotr(item_m[s], pos_m[c]);
        pos_m[c] = pos_m[c] + 1'b1;
    endtask

    task automatic write_item(input sym_t a, input hv_t d);
        logic [31:0] rdata;
        logic        err;
        apb_xfer(1'b1, REG_MEM_ADDR, 32'(a), rdata, err);
        check_err("mem_addr write", 1'b0, err);
        apb_xfer(1'b1, REG_MEM_DATA, d, rdata, err);
        check_err("mem_data write", 1'b0, err);
        item_m[a] = d;
    endtask

    task automatic init_all();
        logic [31:0] rdata;
        logic        err;
        apb_xfer(1'b1, REG_CTRL, 32'h1, rdata, err);
        check_err("init", 1'b0, err);
        for (int k = 0; k < NUM_CORES; k++) begin
            acc_m[k] = '0;
            pos_m[k] = '0;
        end
    endtask

    task automatic capture_all();
        logic [31:0] rdata;
        logic        err;
        apb_xfer(1'b1, REG_CTRL, 32'h2, rdata, err);
        check_err("capture", 1'b0, err);
        chain_m.delete();
        // core 7 sits at the tail
        for (int k = NUM_CORES - 1; k >= 0; k--) begin
            chain_m.push_back(acc_m[k]);
        end
    endtask

    task automatic read_chain(input string name);
        logic [31:0] rdata;
        logic        err;
        hv_t         exp;
        for (int i = 0; i < NUM_CORES; i++) begin
            apb_xfer(1'b0, REG_OUT, 32'h0, rdata, err);
            check_err(name, 1'b0, err);
            exp = chain_m.pop_front();
            // head of the chain shifts in zeros
            chain_m.push_back('0);
            check_hv($sformatf("%s core %0d", name, NUM_CORES - 1 - i), exp, rdata);
        end
    endtask

    initial begin
        logic [31:0] rdata;
        logic        err;
        sym_t        bad_sym;
        core_idx_t   bad_core;
        logic [31:0] bad_addr;
        clk     = 1'b0;
        rst     = 1'b1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        // identity table and cleared state out of reset
        for (int i = 0; i < ITEM_DEPTH; i++) begin
            item_m[i] = hv_t'(i);
        end
        for (int k = 0; k < NUM_CORES; k++) begin
            acc_m[k] = '0;
            pos_m[k] = '0;
        end
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;

        // identity memory on core 0 only
        repeat (12) send_sym(3'd0, rand_sym());
        capture_all();
        read_chain("identity");

        // program every item and then send back to back symbols to random cores
        for (int i = 0; i < ITEM_DEPTH; i++) begin
            write_item(sym_t'(i), hv_t'($random(seed)));
        end
        repeat (200) send_sym(rand_core(), rand_sym());
        capture_all();
        read_chain("random");

        // one core past 32 positions
        repeat (40) send_sym(3'd5, rand_sym());
        capture_all();
        read_chain("wrap");

        init_all();
        repeat (20) send_sym(rand_core(), rand_sym());
        capture_all();
        read_chain("init");

        // rejected transfers must not touch any state
        bad_core = rand_core();
        bad_sym  = sym_t'(ITEM_DEPTH + ($unsigned($random(seed)) % 28));
        apb_xfer(1'b1, REG_SYM, {21'b0, bad_core, 1'b0, bad_sym}, rdata, err);
        check_err("symbol out of range", 1'b1, err);
        // low seven bits of this address alias a valid item
        bad_addr = 32'd128 + ($unsigned($random(seed)) % ITEM_DEPTH);
        apb_xfer(1'b1, REG_MEM_ADDR, bad_addr, rdata, err);
        check_err("large mem_addr write", 1'b0, err);
        apb_xfer(1'b1, REG_MEM_DATA, $random(seed), rdata, err);
        check_err("mem_addr out of range", 1'b1, err);
        apb_xfer(1'b1, 5'h14, $random(seed), rdata, err);
        check_err("unmapped write", 1'b1, err);
        apb_xfer(1'b0, 5'h1C, 32'h0, rdata, err);
        check_err("unmapped read", 1'b1, err);
        // a stray position step or aliased item write shows up in this core
        send_sym(bad_core, sym_t'(bad_addr));
        capture_all();
        read_chain("errors");

        // chain keeps the snapshot while the cores move on
        capture_all();
        repeat (16) send_sym(rand_core(), rand_sym());
        read_chain("isolation");

        $display("Testbench passed");
        $finish;
    end

endmodule

/* hdc.f */
rtl/hdc_pkg.sv
rtl/hdc_ctrl_if.sv
rtl/item_memory.sv
rtl/hdc_core.sv
rtl/hdc_apb_ctrl.sv
rtl/hdc_encoder_top.sv
sim/tb_hdc_encoder.sv

/* Makefile */
LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal --top-module tb_hdc_encoder -f hdc.f -o tb_hdc_encoder
	./obj_dir/tb_hdc_encoder | tee $(LOG)
	grep -q "Testbench passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
